/* all.f */
rv_pkg.sv
rv_decode.sv
rv_execute.sv
rv_writeback.sv
rv_core.sv
tb_clock.sv
tb_rv_core.sv

/* Makefile */
# Verilator build and run of the rv_core testbench

BUILD = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module tb_rv_core \
		-Mdir $(BUILD) -o sim_tb_rv_core

# pass or fail comes from the log, not the simulator exit code
run: compile
	./$(BUILD)/sim_tb_rv_core > sim.log 2>&1; cat sim.log
	grep -qx "ALL CHECKS PASSED" sim.log

clean:
	rm -rf $(BUILD) sim.log

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
    import rv_pkg::*;
();

    localparam int RESET_CYCLES = 8;
    localparam int N_QUIET      = 10;
    localparam int N_B2B        = 400;
    localparam int N_GAP        = 300;
    localparam int N_X0_GROUPS  = 40;
    localparam int N_ILL        = 200;
    // gapped stream may spend two cycles per instruction
    localparam int TEST_CYCLES  = N_QUIET + N_B2B + 2 * N_GAP + 3 * N_X0_GROUPS + N_ILL;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + RESET_CYCLES;

    logic     clk;
    logic     rst_n;
    logic     inst_valid;
    data_t    inst_code;
    logic     wb_valid;
    reg_num_t wb_rd;
    data_t    wb_data;
    logic     illegal_inst;

    integer   seed;
    int       cycle = 0;
    int       errors = 0;
    int       checks = 0;
    int       tests = 0;
    int       err_at_start = 0;
    logic     exp_wb;
    logic     exp_ill;

    // model state and expected events, tagged with the cycle they are due
    data_t    mregs [NUM_REGS];
    int       wb_due_q[$];
    reg_num_t wb_rd_q[$];
    data_t    wb_data_q[$];
    int       ill_due_q[$];

    tb_clock #(.RESET_CYCLES(RESET_CYCLES)) clock_i (
        .clk  (clk),
        .rst_n(rst_n)
    );

    rv_core dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .inst_code   (inst_code),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .illegal_inst(illegal_inst)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic next_rand(output logic [31:0] v);
        v = $random(seed);
    endtask

    // RV32I semantics for the kept subset, straight from the field encodings
    task automatic model_exec(input logic [31:0] inst, output logic legal,
                              output logic [31:0] res);
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        f7  = inst[31:25];
        f3  = inst[14:12];
        a   = mregs[inst[19:15]];
        b   = mregs[inst[24:20]];
        imm = {{20{inst[31]}}, inst[31:20]};
        legal = 1'b0;
        res   = '0;
        if (inst[6:0] == OPC_LUI) begin
            legal = 1'b1;
            res   = {inst[31:12], 12'h000};
        end else if (inst[6:0] == OPC_OP) begin
            legal = 1'b1;
            case ({f7, f3})
                {7'h00, 3'd0}: res = a + b;
                {7'h20, 3'd0}: res = a - b;
                {7'h00, 3'd1}: res = a << b[4:0];
                {7'h00, 3'd2}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                {7'h00, 3'd3}: res = (a < b) ? 32'd1 : 32'd0;
                {7'h00, 3'd4}: res = a ^ b;
                {7'h00, 3'd5}: res = a >> b[4:0];
                {7'h20, 3'd5}: res = $signed(a) >>> b[4:0];
                {7'h00, 3'd6}: res = a | b;
                {7'h00, 3'd7}: res = a & b;
                default:       legal = 1'b0;
            endcase
        end else if (inst[6:0] == OPC_OP_IMM) begin
            legal = 1'b1;
            case (f3)
                3'd0: res = a + imm;
                3'd2: res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
                3'd3: res = (a < imm) ? 32'd1 : 32'd0;
                3'd4: res = a ^ imm;
                3'd6: res = a | imm;
                3'd7: res = a & imm;
                3'd1: begin
                    legal = (f7 == 7'h00);
                    res   = a << inst[24:20];
                end
                default: begin
                    legal = (f7 == 7'h00) || (f7 == 7'h20);
                    // arithmetic shift kept in a statement of its own to stay signed
                    if (f7 == 7'h20) begin
                        res = $signed(a) >>> inst[24:20];
                    end else begin
                        res = a >> inst[24:20];
                    end
                end
            endcase
        end
    endtask

    // drive edge is cycle+1, the DUT samples one edge later
    task automatic model_accept(input logic [31:0] inst);
        logic        legal;
        logic [31:0] res;
        reg_num_t    rd;
        rd = inst[11:7];
        model_exec(inst, legal, res);
        if (legal) begin
            if (rd != '0) begin
                mregs[rd] = res;
            end
            wb_due_q.push_back(cycle + 4);
            wb_rd_q.push_back(rd);
            wb_data_q.push_back(res);
        end else begin
            ill_due_q.push_back(cycle + 2);
        end
    endtask

    task automatic drive_slot(input logic valid, input logic [31:0] code);
        @(posedge clk);
        inst_valid <= valid;
        inst_code  <= code;
        if (valid) begin
            model_accept(code);
        end
    endtask

    // kept instruction over x0..x7
    task automatic gen_kept(output logic [31:0] inst);
        logic [31:0] r;
        logic [31:0] r2;
        logic [6:0]  f7;
        logic [11:0] imm12;
        next_rand(r);
        next_rand(r2);
        f7 = (r[15] && (r[11:9] == 3'd0 || r[11:9] == 3'd5)) ? 7'h20 : 7'h00;
        if (r[14:12] < 3'd4) begin
            inst = {f7, 2'b00, r[8:6], 2'b00, r[5:3], r[11:9], 2'b00, r[2:0], OPC_OP};
        end else if (r[14:12] < 3'd7) begin
            imm12 = r2[11:0];
            if (r[11:9] == 3'd1 || r[11:9] == 3'd5) begin
                imm12 = {(r[11:9] == 3'd5) ? f7 : 7'h00, r2[4:0]};
            end
            inst = {imm12, 2'b00, r[5:3], r[11:9], 2'b00, r[2:0], OPC_OP_IMM};
        end else begin
            inst = {r2[19:0], 2'b00, r[2:0], OPC_LUI};
        end
    endtask

    // opcodes outside the kept set, plus an OP with the M-extension funct7
    task automatic gen_illegal(output logic [31:0] inst);
        logic [31:0] r;
        next_rand(r);
        case (r[2:0])
            3'd0:    inst = {r[31:7], 7'b0000011};
            3'd1:    inst = {r[31:7], 7'b0100011};
            3'd2:    inst = {r[31:7], 7'b1100011};
            3'd3:    inst = {r[31:7], 7'b1101111};
            3'd4:    inst = {r[31:7], 7'b1100111};
            3'd5:    inst = {r[31:7], 7'b0010111};
            3'd6:    inst = {r[31:7], 7'b1110011};
            default: inst = {7'h01, r[24:7], OPC_OP};
        endcase
    endtask

    task automatic finish_test(input string name);
        drive_slot(1'b0, '0);
        while (wb_due_q.size() != 0 || ill_due_q.size() != 0) begin
            @(posedge clk);
        end
        tests++;
        $display("test %0s: %0s, %0d errors", name,
                 (errors == err_at_start) ? "ok" : "failed", errors - err_at_start);
        err_at_start = errors;
    endtask

    task automatic run_gapped();
        logic [31:0] r;
        logic [31:0] inst;
        for (int i = 0; i < N_GAP; i++) begin
            next_rand(r);
            // idle slot carries a random code that must not retire
            if (r[1:0] == 2'b00) begin
                drive_slot(1'b0, r);
            end
            gen_kept(inst);
            drive_slot(1'b1, inst);
        end
    endtask

    task automatic run_x0();
        logic [31:0] r;
        logic [31:0] inst;
        reg_num_t    rd;
        for (int i = 0; i < N_X0_GROUPS; i++) begin
            gen_kept(inst);
            inst[11:7] = '0;
            drive_slot(1'b1, inst);
            next_rand(r);
            rd = (r[2:0] == 3'd0) ? 5'd1 : {2'b00, r[2:0]};
            // OR rd, x0, x0 then ADDI rd, x0, imm
            drive_slot(1'b1, {7'h00, 5'd0, 5'd0, 3'b110, rd, OPC_OP});
            drive_slot(1'b1, {r[31:20], 5'd0, 3'b000, rd, OPC_OP_IMM});
        end
    endtask

    task automatic run_illegal();
        logic [31:0] r;
        logic [31:0] inst;
        for (int i = 0; i < N_ILL; i++) begin
            next_rand(r);
            if (r[1:0] == 2'b00) begin
                gen_illegal(inst);
            end else begin
                gen_kept(inst);
            end
            drive_slot(1'b1, inst);
        end
    endtask

    // outputs compared mid-cycle, away from the edge
    always @(negedge clk) begin
        // DUT flops are unknown until the first reset edge
        if (cycle > 0) begin
            exp_wb  = (wb_due_q.size() != 0) && (wb_due_q[0] == cycle);
            exp_ill = (ill_due_q.size() != 0) && (ill_due_q[0] == cycle);
            checks += 2;
            assert (wb_valid == exp_wb) else begin
                $display("FAIL %0t wb_valid expected %0b got %0b", $time, exp_wb, wb_valid);
                errors++;
            end
            assert (illegal_inst == exp_ill) else begin
                $display("FAIL %0t illegal_inst expected %0b got %0b", $time, exp_ill,
                         illegal_inst);
                errors++;
            end
            if (exp_wb) begin
                checks += 2;
                assert (wb_rd == wb_rd_q[0]) else begin
                    $display("FAIL %0t wb_rd expected %0d got %0d", $time, wb_rd_q[0],
                             wb_rd);
                    errors++;
                end
                assert (wb_data == wb_data_q[0]) else begin
                    $display("FAIL %0t wb_data expected %08h got %08h", $time,
                             wb_data_q[0], wb_data);
                    errors++;
                end
                void'(wb_due_q.pop_front());
                void'(wb_rd_q.pop_front());
                void'(wb_data_q.pop_front());
            end
            if (exp_ill) begin
                void'(ill_due_q.pop_front());
            end
        end
    end

    initial begin
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] inst;
        inst_valid <= 1'b0;
        inst_code  <= '0;
        seed = 40;
        for (int i = 0; i < NUM_REGS; i++) begin
            mregs[i] = '0;
        end
        while (rst_n !== 1'b1) begin
            @(posedge clk);
        end
        repeat (N_QUIET) drive_slot(1'b0, '0);
        finish_test("reset quiet");
        for (int i = 0; i < N_B2B; i++) begin
            gen_kept(inst);
            drive_slot(1'b1, inst);
        end
        finish_test("back-to-back stream");
        run_gapped();
        finish_test("gapped stream");
        run_x0();
        finish_test("x0 handling");
        run_illegal();
        finish_test("illegal encodings");
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb_rv_core

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // synchronous reset, low for the first RESET_CYCLES edges
    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule : tb_clock

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        inst_valid,
    input  wire data_t inst_code,
    output logic       wb_valid,
    output reg_num_t   wb_rd,
    output data_t      wb_data,
    output logic       illegal_inst
);

    // register file read ports
    reg_num_t rf_rs1;
    reg_num_t rf_rs2;
    data_t    rf_rs1_data;
    data_t    rf_rs2_data;

    // decode pipeline register
    logic     de_valid;
    alu_op_t  de_op;
    data_t    de_a;
    data_t    de_b;
    reg_num_t de_rd;

    // execute outputs, live and registered
    data_t    ex_alu_result;
    logic     ex_valid;
    reg_num_t ex_rd;
    data_t    ex_result;

    // the decode register loops back as the tag of the live ALU result
    rv_decode decode_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst_code    (inst_code),
        .rf_rs1_data  (rf_rs1_data),
        .rf_rs2_data  (rf_rs2_data),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_result    (ex_result),
        .fwd_ex_valid (de_valid),
        .fwd_ex_rd    (de_rd),
        .ex_alu_result(ex_alu_result),
        .rf_rs1       (rf_rs1),
        .rf_rs2       (rf_rs2),
        .de_valid     (de_valid),
        .de_op        (de_op),
        .de_a         (de_a),
        .de_b         (de_b),
        .de_rd        (de_rd),
        .illegal_inst (illegal_inst)
    );

    rv_execute execute_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .de_valid     (de_valid),
        .de_op        (de_op),
        .de_a         (de_a),
        .de_b         (de_b),
        .de_rd        (de_rd),
        .ex_alu_result(ex_alu_result),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_result    (ex_result)
    );

    rv_writeback writeback_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_valid   (ex_valid),
        .ex_rd      (ex_rd),
        .ex_result  (ex_result),
        .rf_rs1     (rf_rs1),
        .rf_rs2     (rf_rs2),
        .rf_rs1_data(rf_rs1_data),
        .rf_rs2_data(rf_rs2_data),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule : rv_core

`default_nettype wire

/* rv_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_writeback
    import rv_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire           ex_valid,
    input  wire reg_num_t ex_rd,
    input  wire data_t    ex_result,
    input  wire reg_num_t rf_rs1,
    input  wire reg_num_t rf_rs2,
    output data_t         rf_rs1_data,
    output data_t         rf_rs2_data,
    output logic          wb_valid,
    output reg_num_t      wb_rd,
    output data_t         wb_data
);

    data_t regs [NUM_REGS];

    // x0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ex_valid && ex_rd != '0) begin
            regs[ex_rd] <= ex_result;
        end
    end

    // two asynchronous read ports for decode
    assign rf_rs1_data = regs[rf_rs1];
    assign rf_rs2_data = regs[rf_rs2];

    // retirement report, data shown even for rd == x0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_rd    <= '0;
            wb_data  <= '0;
        end else begin
            wb_valid <= ex_valid;
            wb_rd    <= ex_rd;
            wb_data  <= ex_result;
        end
    end

endmodule : rv_writeback

`default_nettype wire

/* rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute
    import rv_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire           de_valid,
    input  wire alu_op_t  de_op,
    input  wire data_t    de_a,
    input  wire data_t    de_b,
    input  wire reg_num_t de_rd,
    output data_t         ex_alu_result,
    output logic          ex_valid,
    output reg_num_t      ex_rd,
    output data_t         ex_result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // shifts only look at the low five bits of b
    assign shamt       = de_b[4:0];
    assign lt_signed   = $signed(de_a) < $signed(de_b);
    assign lt_unsigned = de_a < de_b;

    always_comb begin
        case (de_op)
            ALU_ADD: begin
                ex_alu_result = de_a + de_b;
            end
            ALU_SUB: begin
                ex_alu_result = de_a - de_b;
            end
            ALU_SLL: begin
                ex_alu_result = de_a << shamt;
            end
            ALU_SLT: begin
                ex_alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                ex_alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_XOR: begin
                ex_alu_result = de_a ^ de_b;
            end
            ALU_SRL: begin
                ex_alu_result = de_a >> shamt;
            end
            ALU_SRA: begin
                ex_alu_result = data_t'($signed(de_a) >>> shamt);
            end
            ALU_OR: begin
                ex_alu_result = de_a | de_b;
            end
            ALU_AND: begin
                ex_alu_result = de_a & de_b;
            end
            ALU_PASS_B: begin
                ex_alu_result = de_b;
            end
            default: begin
                ex_alu_result = '0;
            end
        endcase
    end

    // result held here for one cycle until the register file takes it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid  <= 1'b0;
            ex_rd     <= '0;
            ex_result <= '0;
        end else begin
            ex_valid  <= de_valid;
            ex_rd     <= de_rd;
            ex_result <= ex_alu_result;
        end
    end

endmodule : rv_execute

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode
    import rv_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire           inst_valid,
    input  wire data_t    inst_code,
    input  wire data_t    rf_rs1_data,
    input  wire data_t    rf_rs2_data,
    input  wire           ex_valid,
    input  wire reg_num_t ex_rd,
    input  wire data_t    ex_result,
    input  wire           fwd_ex_valid,
    input  wire reg_num_t fwd_ex_rd,
    input  wire data_t    ex_alu_result,
    output reg_num_t      rf_rs1,
    output reg_num_t      rf_rs2,
    output logic          de_valid,
    output alu_op_t       de_op,
    output data_t         de_a,
    output data_t         de_b,
    output reg_num_t      de_rd,
    output logic          illegal_inst
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_num_t   rd_field;
    data_t      imm_i;
    data_t      imm_u;
    data_t      rs1_val;
    data_t      rs2_val;
    alu_op_t    op_next;
    data_t      b_next;
    logic       legal;

    // funct3 to operation, alt selects SUB/SRA
    function automatic alu_op_t dec_op(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        op = ALU_ADD;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    // youngest producer first, then the result waiting for the register file
    function automatic data_t pick_operand(input reg_num_t rs, input data_t rf_data);
        data_t val;
        val = rf_data;
        if (fwd_ex_valid && fwd_ex_rd != '0 && fwd_ex_rd == rs) begin
            val = ex_alu_result;
        end else if (ex_valid && ex_rd != '0 && ex_rd == rs) begin
            val = ex_result;
        end
        return val;
    endfunction

    assign opcode   = inst_code[6:0];
    assign rd_field = inst_code[11:7];
    assign funct3   = inst_code[14:12];
    assign funct7   = inst_code[31:25];
    assign rf_rs1   = inst_code[19:15];
    assign rf_rs2   = inst_code[24:20];

    // low five bits of the I immediate double as shamt
    assign imm_i = {{(XLEN-12){inst_code[31]}}, inst_code[31:20]};
    assign imm_u = {inst_code[31:12], 12'h000};

    always_comb begin
        rs1_val = pick_operand(rf_rs1, rf_rs1_data);
        rs2_val = pick_operand(rf_rs2, rf_rs2_data);
    end

    always_comb begin
        legal   = 1'b0;
        op_next = ALU_ADD;
        b_next  = rs2_val;
        case (opcode)
            OPC_OP: begin
                op_next = dec_op(funct3, funct7 == F7_ALT);
                legal   = (funct7 == '0) ||
                          (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
            end
            OPC_OP_IMM: begin
                b_next  = imm_i;
                // ADDI has no alternate form, only the right shift does
                op_next = dec_op(funct3, funct3 == F3_SRL_SRA && funct7 == F7_ALT);
                case (funct3)
                    F3_SLL:     legal = (funct7 == '0);
                    F3_SRL_SRA: legal = (funct7 == '0) || (funct7 == F7_ALT);
                    default:    legal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                legal   = 1'b1;
                op_next = ALU_PASS_B;
                b_next  = imm_u;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_valid     <= 1'b0;
            illegal_inst <= 1'b0;
            de_op        <= ALU_ADD;
            de_a         <= '0;
            de_b         <= '0;
            de_rd        <= '0;
        end else begin
            de_valid     <= inst_valid && legal;
            illegal_inst <= inst_valid && !legal;
            de_op        <= op_next;
            de_a         <= rs1_val;
            de_b         <= b_next;
            de_rd        <= rd_field;
        end
    end

endmodule : rv_decode

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // datapath and register file sizes
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // major opcodes kept from RV32I
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 field values, shared by the register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 value picking SUB over ADD and SRA over SRL
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // operation handed from decode to the ALU
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // operand b straight through, used by LUI
        ALU_PASS_B
    } alu_op_t;

    typedef logic [XLEN-1:0]       data_t;
    typedef logic [REG_ADDR_W-1:0] reg_num_t;

endpackage : rv_pkg

`default_nettype wire
